/* bench/periph_asserts.sv */
// Bus and serial line assertions
// Bound into the peripheral top level
module periph_asserts (
    input logic clk,
    input logic reset_i,
    input logic sel_i,
    input logic ack_i,
    input logic tx_i,
    input logic tx_busy_i
);

    // Ack is a single-cycle pulse
    property ack_single_cycle;
        @(posedge clk) disable iff (reset_i) ack_i |=> !ack_i;
    endproperty

    // Ack answers a select seen the cycle before
    property ack_follows_sel;
        @(posedge clk) disable iff (reset_i) $rose(ack_i) |-> $past(sel_i);
    endproperty

    // Line rests high while the UART has nothing to send
    property tx_idle_high;
        @(posedge clk) disable iff (reset_i) !tx_busy_i |-> tx_i;
    endproperty

    a_ack_single_cycle: assert property (ack_single_cycle)
        else $error("ack_o stayed high for two cycles");
    a_ack_follows_sel: assert property (ack_follows_sel)
        else $error("ack_o rose without sel_i the cycle before");
    a_tx_idle_high: assert property (tx_idle_high)
        else $error("tx_o low while the UART is not busy");

endmodule

bind periph_top periph_asserts i_periph_asserts (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (sel_i),
    .ack_i     (ack_o),
    .tx_i      (tx_o),
    .tx_busy_i (tx_busy)
);

/* bench/periph_tb.sv */
// Peripheral block testbench
// Drives the bus and the keyboard strobe and rebuilds bytes from the serial line
module periph_tb;
    import bus_pkg::*;

    localparam int FREQ_HZ      = 800_000;
    localparam int BAUDS        = 100_000;
    localparam int CLKS_PER_BIT = FREQ_HZ / BAUDS;
    localparam int TX_DEPTH     = 4;
    localparam int KBD_DEPTH    = 4;
    localparam int ACK_WAIT     = 4;
    // Three frames and then a full buffer with one in flight, with a margin for bus traffic
    localparam int CYCLE_LIMIT  = (3 + TX_DEPTH + 1) * 10 * CLKS_PER_BIT + 1000;

    logic        clk;
    logic        reset;
    logic        sel;
    logic        we;
    addr_t       addr;
    data_t       wdata;
    logic        ack;
    data_t       rdata;
    logic [7:0]  display;
    logic        tx;
    logic [7:0]  kbd_code;
    logic        kbd_strobe;
    logic        kbd_err;
    logic [31:0] lfsr_q;
    logic [7:0]  rx_q[$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_errors;
    int          cycles;
    string       test_name;

    periph_top #(
        .FREQ_HZ   (FREQ_HZ),
        .BAUDS     (BAUDS),
        .TX_DEPTH  (TX_DEPTH),
        .KBD_DEPTH (KBD_DEPTH)
    ) i_periph_top (
        .clk          (clk),
        .reset_i      (reset),
        .sel_i        (sel),
        .we_i         (we),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .ack_o        (ack),
        .rdata_o      (rdata),
        .display_o    (display),
        .tx_o         (tx),
        .kbd_code_i   (kbd_code),
        .kbd_strobe_i (kbd_strobe),
        .kbd_err_i    (kbd_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    function automatic addr_t reg_addr(input logic [3:0] dev, input logic [11:0] ofs);
        return {REGION_PERIPH, 12'h000, dev, ofs};
    endfunction

    task automatic compare_word(input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("ERROR %s: expected %0h, actual %0h", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic require_that(input logic cond, input string what);
        assert (cond) else begin
            $display("Test %s went wrong: %s", test_name, what);
            errors++;
        end
    endtask

    // One bus cycle that gives up after ACK_WAIT cycles without ack
    task automatic access(input logic wr, input addr_t a, input data_t d,
                          output data_t q, output logic acked);
        acked = 1'b0;
        q = '0;
        @(negedge clk);
        sel = 1'b1;
        we = wr;
        addr = a;
        wdata = d;
        for (int i = 0; i < ACK_WAIT && !acked; i++) begin
            @(negedge clk);
            if (ack) begin
                acked = 1'b1;
                q = rdata;
            end
        end
        // Inputs stay put through the ack cycle so a write lands at its closing edge
        @(negedge clk);
        sel = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_word(input addr_t a, input data_t d);
        data_t q;
        logic  acked;
        access(1'b1, a, d, q, acked);
        require_that(acked, "write got no acknowledge");
    endtask

    task automatic read_word(input addr_t a, output data_t q);
        logic acked;
        access(1'b0, a, '0, q, acked);
        require_that(acked, "read got no acknowledge");
    endtask

    task automatic wait_uart_idle();
        data_t q;
        read_word(reg_addr(DEV_UART, OFS_STATUS), q);
        while (q[0]) begin
            read_word(reg_addr(DEV_UART, OFS_STATUS), q);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", test_name);
        end
    endtask

    // Serial monitor that samples each bit near its middle
    initial begin
        logic [7:0] b;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (tx == 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                require_that(tx == 1'b0, "start bit is not low at mid-bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                require_that(tx == 1'b1, "stop bit is not high");
                rx_q.push_back(b);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        data_t      q;
        logic       acked;
        logic       found;
        logic [7:0] value;
        logic [7:0] sent[$];
        logic [7:0] codes[5];
        logic [7:0] got_code[$];
        logic       got_err[$];
        int         j;

        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        lfsr_q = 32'hf09d;
        reset = 1'b1;
        sel = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        kbd_code = '0;
        kbd_strobe = 1'b0;
        kbd_err = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        start_test("display");
        value = random_byte();
        write_word(reg_addr(DEV_DISPLAY, OFS_DATA), {24'd0, value});
        // Bit 7 is the halt flag and must still be clear
        compare_word({25'd0, value[6:0]}, {24'd0, display});
        end_test();

        start_test("uart_frames");
        rx_q.delete();
        sent.delete();
        repeat (3) begin
            value = random_byte();
            sent.push_back(value);
            write_word(reg_addr(DEV_UART, OFS_DATA), {24'd0, value});
        end
        wait_uart_idle();
        compare_word(sent.size(), rx_q.size());
        foreach (rx_q[i]) begin
            if (i < sent.size()) begin
                compare_word({24'd0, sent[i]}, {24'd0, rx_q[i]});
            end
        end
        end_test();

        start_test("uart_overflow");
        rx_q.delete();
        sent.delete();
        repeat (6) begin
            value = random_byte();
            sent.push_back(value);
            write_word(reg_addr(DEV_UART, OFS_DATA), {24'd0, value});
        end
        read_word(reg_addr(DEV_UART, OFS_STATUS), q);
        compare_word(32'd1, {31'd0, q[0]});
        wait_uart_idle();
        require_that(rx_q.size() >= 1 && rx_q.size() <= TX_DEPTH + 1,
                     "received byte count is out of range");
        // Received bytes must appear among the written ones in the same order
        j = 0;
        foreach (rx_q[i]) begin
            found = 1'b0;
            while (j < sent.size() && !found) begin
                found = sent[j] == rx_q[i];
                j++;
            end
            require_that(found, "received a byte that was not written in that order");
        end
        end_test();

        start_test("keyboard");
        for (int i = 0; i < 5; i++) begin
            codes[i] = random_byte();
            @(negedge clk);
            kbd_code = codes[i];
            kbd_err = i == 2;
            kbd_strobe = 1'b1;
            @(negedge clk);
            kbd_strobe = 1'b0;
            kbd_err = 1'b0;
        end
        got_code.delete();
        got_err.delete();
        read_word(reg_addr(DEV_KBD, KBD_OFS_STATUS), q);
        while (q[0] && got_code.size() < 8) begin
            write_word(reg_addr(DEV_KBD, KBD_OFS_STATUS), '0);
            read_word(reg_addr(DEV_KBD, KBD_OFS_CODE), q);
            got_code.push_back(q[7:0]);
            // Error bit of the entry just dequeued
            read_word(reg_addr(DEV_KBD, KBD_OFS_STATUS), q);
            got_err.push_back(q[1]);
        end
        compare_word(KBD_DEPTH, got_code.size());
        foreach (got_code[i]) begin
            if (i < 5) begin
                compare_word({24'd0, codes[i]}, {24'd0, got_code[i]});
                compare_word((i == 2) ? 32'd1 : 32'd0, {31'd0, got_err[i]});
            end
        end
        end_test();

        start_test("unmapped");
        access(1'b0, reg_addr(DEV_UART, 12'h008), '0, q, acked);
        require_that(acked, "unmapped read got no acknowledge");
        compare_word(32'd0, q);
        end_test();

        start_test("halt");
        access(1'b0, 32'h0000_1000, '0, q, acked);
        require_that(!acked, "access outside the region was acknowledged");
        compare_word(32'd1, {31'd0, display[7]});
        access(1'b0, reg_addr(DEV_DISPLAY, OFS_DATA), '0, q, acked);
        require_that(!acked, "access while halted was acknowledged");
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* list.f */
src/bus_pkg.sv
src/periph_pkg.sv
src/sync_fifo.sv
src/baud_timer.sv
src/uart_tx_fsm.sv
src/kbd_port.sv
src/bus_decoder.sv
src/periph_top.sv
bench/periph_asserts.sv
bench/periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module periph_tb -Mdir obj_dir -o periph_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/periph_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

/* src/baud_timer.sv */
// Baud timer
// Down-counter that pulses once per serial bit period
module baud_timer #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic clk,
    input  logic reset_i,
    input  logic restart_i,
    output logic tick_o
);

    localparam int CW = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (reset_i || restart_i) begin
            cnt_q <= RELOAD;
        end else if (cnt_q == '0) begin
            cnt_q <= RELOAD;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // First tick a full bit period after restart
    assign tick_o = cnt_q == '0;

endmodule

/* src/bus_decoder.sv */
// Peripheral bus decoder
// Registers the acknowledge, keeps the halt flag and the display register,
// and turns device accesses into strobes and a read word
module bus_decoder (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           sel_i,
    input  logic           we_i,
    input  bus_pkg::addr_t addr_i,
    input  bus_pkg::data_t wdata_i,
    output logic           ack_o,
    output bus_pkg::data_t rdata_o,
    output logic [7:0]     display_o,
    output logic           tx_push_o,
    input  logic           tx_full_i,
    input  logic           tx_busy_i,
    output logic           kbd_pop_o,
    input  logic           kbd_avail_i,
    input  logic           kbd_err_i,
    input  logic [7:0]     kbd_code_i
);
    import bus_pkg::*;

    logic        sel_q;
    logic        start;
    logic        region_ok;
    logic [3:0]  dev;
    logic [11:0] ofs;
    logic        wr;
    logic        halt_q;
    logic [6:0]  display_q;

    assign region_ok = addr_i[31:28] == REGION_PERIPH;
    assign dev       = addr_i[15:12];
    assign ofs       = addr_i[11:0];

    // An access starts on the first cycle sel is seen
    assign start = sel_i && !sel_q;
    assign wr    = ack_o && we_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_q     <= 1'b0;
            ack_o     <= 1'b0;
            halt_q    <= 1'b0;
            display_q <= '0;
        end else begin
            sel_q <= sel_i;
            ack_o <= start && region_ok && !halt_q;
            // Anything outside the peripheral region halts for good
            if (start && !region_ok) begin
                halt_q <= 1'b1;
            end
            if (wr && dev == DEV_DISPLAY && ofs == OFS_DATA) begin
                display_q <= wdata_i[6:0];
            end
        end
    end

    assign display_o = {halt_q, display_q};

    // Strobes fire in the ack cycle and take effect at its closing edge
    assign tx_push_o = wr && dev == DEV_UART && ofs == OFS_DATA && !tx_full_i;
    assign kbd_pop_o = wr && dev == DEV_KBD && ofs == KBD_OFS_STATUS && kbd_avail_i;

    always_comb begin
        rdata_o = '0;
        case (dev)
            DEV_DISPLAY: begin
                if (ofs == OFS_DATA) begin
                    rdata_o = {24'd0, display_o};
                end
            end
            DEV_UART: begin
                // No receiver, so the valid bit stays zero
                if (ofs == OFS_STATUS) begin
                    rdata_o = {30'd0, 1'b0, tx_busy_i};
                end
            end
            DEV_KBD: begin
                if (ofs == KBD_OFS_STATUS) begin
                    rdata_o = {30'd0, kbd_err_i, kbd_avail_i};
                end else if (ofs == KBD_OFS_CODE) begin
                    rdata_o = {24'd0, kbd_code_i};
                end
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

/* src/bus_pkg.sv */
// Bus package
// Address map, bus word types and register offsets of the peripheral region
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Region code in address bits 31:28
    localparam logic [3:0] REGION_PERIPH = 4'h2;

    // Device codes in address bits 15:12
    localparam logic [3:0] DEV_DISPLAY = 4'h1;
    localparam logic [3:0] DEV_UART    = 4'h2;
    localparam logic [3:0] DEV_KBD     = 4'h5;

    // Register offsets in address bits 11:0
    localparam logic [11:0] OFS_DATA   = 12'h000;
    localparam logic [11:0] OFS_STATUS = 12'h004;

    // Keyboard puts status first and code second
    localparam logic [11:0] KBD_OFS_STATUS = 12'h000;
    localparam logic [11:0] KBD_OFS_CODE   = 12'h004;

endpackage

/* src/kbd_port.sv */
// Keyboard port
// Buffers strobed scan codes and holds the last dequeued code and error flag
module kbd_port #(
    parameter int KBD_DEPTH = periph_pkg::KBD_DEPTH_DEFAULT
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] kbd_code_i,
    input  logic       kbd_strobe_i,
    input  logic       kbd_err_i,
    input  logic       pop_i,
    output logic       avail_o,
    output logic [7:0] code_o,
    output logic       err_o
);
    import periph_pkg::*;

    kbd_entry_t din;
    kbd_entry_t head;
    logic       full;
    logic       empty;

    assign din.code = kbd_code_i;
    assign din.err  = kbd_err_i;

    sync_fifo #(
        .payload_t (kbd_entry_t),
        .DEPTH     (KBD_DEPTH)
    ) i_kbd_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (kbd_strobe_i && !full),
        .din_i   (din),
        .full_o  (full),
        .pop_i   (pop_i && !empty),
        .dout_o  (head),
        .empty_o (empty)
    );

    assign avail_o = !empty;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_o <= 1'b0;
        end else if (pop_i && !empty) begin
            err_o <= head.err;
        end
    end

    // Code register loads with the dequeue
    always_ff @(posedge clk) begin
        if (pop_i && !empty) begin
            code_o <= head.code;
        end
    end

endmodule

/* src/periph_pkg.sv */
// Peripheral package
// Payload types and default buffer depths for the UART and the keyboard
package periph_pkg;

    // Byte waiting in the UART transmit buffer
    typedef logic [7:0] tx_byte_t;

    // Scan code and its error flag as one FIFO entry
    typedef struct packed {
        logic       err;
        logic [7:0] code;
    } kbd_entry_t;

    localparam int TX_DEPTH_DEFAULT  = 4;
    localparam int KBD_DEPTH_DEFAULT = 32;

endpackage

/* src/periph_top.sv */
// Peripheral block top level
// Bus decoder, UART transmit path and keyboard port behind one select/ack bus
module periph_top #(
    parameter int FREQ_HZ   = 12_000_000,
    parameter int BAUDS     = 115_200,
    parameter int TX_DEPTH  = periph_pkg::TX_DEPTH_DEFAULT,
    parameter int KBD_DEPTH = periph_pkg::KBD_DEPTH_DEFAULT
) (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           sel_i,
    input  logic           we_i,
    input  bus_pkg::addr_t addr_i,
    input  bus_pkg::data_t wdata_i,
    output logic           ack_o,
    output bus_pkg::data_t rdata_o,
    output logic [7:0]     display_o,
    output logic           tx_o,
    input  logic [7:0]     kbd_code_i,
    input  logic           kbd_strobe_i,
    input  logic           kbd_err_i
);
    import periph_pkg::*;

    localparam int CLKS_PER_BIT = FREQ_HZ / BAUDS;

    logic     tx_push;
    logic     tx_full;
    logic     tx_empty;
    logic     tx_take;
    tx_byte_t tx_head;
    logic     tx_busy;
    logic     fsm_busy;
    logic     tick;
    logic     restart;
    logic     kbd_pop;
    logic     kbd_avail;
    logic     kbd_err;
    logic [7:0] kbd_code;

    // Busy until the buffer drains and the last frame is out
    assign tx_busy = fsm_busy || !tx_empty;

    bus_decoder i_bus_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .sel_i       (sel_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .display_o   (display_o),
        .tx_push_o   (tx_push),
        .tx_full_i   (tx_full),
        .tx_busy_i   (tx_busy),
        .kbd_pop_o   (kbd_pop),
        .kbd_avail_i (kbd_avail),
        .kbd_err_i   (kbd_err),
        .kbd_code_i  (kbd_code)
    );

    sync_fifo #(
        .payload_t (tx_byte_t),
        .DEPTH     (TX_DEPTH)
    ) i_tx_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (tx_push),
        .din_i   (wdata_i[7:0]),
        .full_o  (tx_full),
        .pop_i   (tx_take),
        .dout_o  (tx_head),
        .empty_o (tx_empty)
    );

    baud_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_baud_timer (
        .clk       (clk),
        .reset_i   (reset_i),
        .restart_i (restart),
        .tick_o    (tick)
    );

    uart_tx_fsm i_uart_tx_fsm (
        .clk          (clk),
        .reset_i      (reset_i),
        .byte_valid_i (!tx_empty),
        .byte_i       (tx_head),
        .byte_take_o  (tx_take),
        .tick_i       (tick),
        .restart_o    (restart),
        .busy_o       (fsm_busy),
        .tx_o         (tx_o)
    );

    kbd_port #(
        .KBD_DEPTH (KBD_DEPTH)
    ) i_kbd_port (
        .clk          (clk),
        .reset_i      (reset_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .kbd_err_i    (kbd_err_i),
        .pop_i        (kbd_pop),
        .avail_o      (kbd_avail),
        .code_o       (kbd_code),
        .err_o        (kbd_err)
    );

endmodule

/* src/sync_fifo.sv */
// Synchronous FIFO
// First-word-fall-through circular buffer with a type-parameterized payload
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     push_i,
    input  payload_t din_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t dout_o,
    output logic     empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    assign full_o  = count_q == CW'(DEPTH);
    assign empty_o = count_q == '0;
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head is visible without a read cycle
    assign dout_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* src/uart_tx_fsm.sv */
// UART transmit FSM
// Serializes bytes from the buffer head into 8N1 frames, LSB first
module uart_tx_fsm (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 byte_valid_i,
    input  periph_pkg::tx_byte_t byte_i,
    output logic                 byte_take_o,
    input  logic                 tick_i,
    output logic                 restart_o,
    output logic                 busy_o,
    output logic                 tx_o
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t     state_q;
    tx_byte_t   shift_q;
    logic [2:0] bit_cnt_q;

    // Take the head byte and line up the bit timer in the same cycle
    assign byte_take_o = (state_q == IDLE) && byte_valid_i;
    assign restart_o   = byte_take_o;
    assign busy_o      = state_q != IDLE;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (byte_take_o) begin
                        state_q <= START;
                    end
                end
                START: begin
                    if (tick_i) begin
                        state_q   <= DATA;
                        bit_cnt_q <= '0;
                    end
                end
                DATA: begin
                    if (tick_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= STOP;
                        end
                    end
                end
                default: begin
                    if (tick_i) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_take_o) begin
            shift_q <= byte_i;
        end else if (state_q == DATA && tick_i) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            START:   tx_o = 1'b0;
            DATA:    tx_o = shift_q[0];
            default: tx_o = 1'b1;
        endcase
    end

endmodule
